// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rv_datapath
FILELIST  ?= rv_datapath.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Everything OK

.PHONY: sim clean

# the run fails unless the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== design/alu_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_exec (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      inst_valid_i,
    input  logic [rv_pkg::XLEN-1:0]   inst_addr_i,
    input  rv_pkg::alu_op_e           alu_op_i,
    input  logic [rv_pkg::XLEN-1:0]   imm_i,
    input  logic                      use_imm_i,
    input  logic                      use_pc_i,
    input  logic                      word_op_i,
    input  logic                      illegal_i,
    input  logic [rv_pkg::REG_AW-1:0] rd_addr_i,
    input  logic [rv_pkg::XLEN-1:0]   rs1_data_i,
    input  logic [rv_pkg::XLEN-1:0]   rs2_data_i,
    output logic                      wb_valid_o,
    output logic [rv_pkg::REG_AW-1:0] wb_addr_o,
    output logic [rv_pkg::XLEN-1:0]   wb_data_o,
    output logic                      illegal_o
);
    import rv_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [5:0]      shamt;
    logic [XLEN-1:0] srl_src;
    logic [XLEN-1:0] sra_src;
    logic [XLEN-1:0] raw_result;
    logic [XLEN-1:0] result;

    assign op_a = use_pc_i ? inst_addr_i : rs1_data_i;
    assign op_b = use_imm_i ? imm_i : rs2_data_i;

    // word shifts only see 5 bits of amount
    assign shamt = word_op_i ? {1'b0, op_b[4:0]} : op_b[5:0];

    // right shifts in word form work on the low half of a
    assign srl_src = word_op_i ? {{(XLEN-32){1'b0}}, op_a[31:0]} : op_a;
    assign sra_src = word_op_i ? {{(XLEN-32){op_a[31]}}, op_a[31:0]} : op_a;

    always_comb begin
        case (alu_op_i)
            ALU_ADD:    raw_result = op_a + op_b;
            ALU_SUB:    raw_result = op_a - op_b;
            ALU_SLL:    raw_result = op_a << shamt;
            ALU_SLT:    raw_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   raw_result = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:    raw_result = op_a ^ op_b;
            ALU_SRL:    raw_result = srl_src >> shamt;
            ALU_SRA:    raw_result = $unsigned($signed(sra_src) >>> shamt);
            ALU_OR:     raw_result = op_a | op_b;
            ALU_AND:    raw_result = op_a & op_b;
            ALU_PASS_B: raw_result = op_b;
            default:    raw_result = '0;
        endcase
    end

    // word forms sign-extend from bit 31
    assign result = word_op_i ? {{(XLEN-32){raw_result[31]}}, raw_result[31:0]} : raw_result;

    // pulses, one cycle after the sampled strobe
    always_ff @(posedge clk) begin
        if (!rst) begin
            wb_valid_o <= 1'b0;
            illegal_o  <= 1'b0;
        end else begin
            wb_valid_o <= inst_valid_i && !illegal_i;
            illegal_o  <= inst_valid_i && illegal_i;
        end
    end

    // payload, only qualified by wb_valid_o
    always_ff @(posedge clk) begin
        if (inst_valid_i && !illegal_i) begin
            wb_addr_o <= rd_addr_i;
            wb_data_o <= result;
        end
    end

endmodule

`default_nettype wire

// ==== design/inst_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_decode (
    input  logic [rv_pkg::INST_W-1:0] inst_i,
    output logic [rv_pkg::REG_AW-1:0] rs1_addr_o,
    output logic [rv_pkg::REG_AW-1:0] rs2_addr_o,
    output logic [rv_pkg::REG_AW-1:0] rd_addr_o,
    output rv_pkg::alu_op_e           alu_op_o,
    output logic [rv_pkg::XLEN-1:0]   imm_o,
    output logic                      use_imm_o,
    output logic                      use_pc_o,
    output logic                      word_op_o,
    output logic                      illegal_o
);
    import rv_pkg::*;

    opcode_e           opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    logic [XLEN-1:0]   imm_i_type;
    logic [XLEN-1:0]   imm_u_type;
    logic [XLEN-1:0]   imm_shamt;

    // funct3 to base operation, shared by op and op-imm
    function automatic alu_op_e base_op(input logic [2:0] f3);
        case (f3)
            3'b000:  return ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign opcode = opcode_e'(inst_i[6:0]);
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];
    assign rd_addr_o  = inst_i[11:7];

    assign imm_i_type = {{(XLEN-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_u_type = {{(XLEN-32){inst_i[31]}}, inst_i[31:12], 12'b0};
    assign imm_shamt  = {{(XLEN-6){1'b0}}, inst_i[25:20]}; // alu trims to 5 bits for words

    always_comb begin
        alu_op_o  = ALU_ADD;
        imm_o     = imm_i_type;
        use_imm_o = 1'b0;
        use_pc_o  = 1'b0;
        word_op_o = 1'b0;
        illegal_o = 1'b0;

        case (opcode)
            OPC_OP_IMM: begin
                use_imm_o = 1'b1;
                alu_op_o  = base_op(funct3);
                if (funct3 == 3'b001) begin
                    imm_o     = imm_shamt;
                    illegal_o = (inst_i[31:26] != 6'b000000); // 6-bit shamt
                end else if (funct3 == 3'b101) begin
                    imm_o = imm_shamt;
                    if (inst_i[31:26] == 6'b010000)
                        alu_op_o = ALU_SRA; // srai bit set
                    else if (inst_i[31:26] != 6'b000000)
                        illegal_o = 1'b1;
                end
            end
            OPC_OP_IMM_32: begin
                use_imm_o = 1'b1;
                word_op_o = 1'b1;
                case (funct3)
                    3'b000: alu_op_o = ALU_ADD; // addiw
                    3'b001: begin
                        imm_o     = imm_shamt;
                        alu_op_o  = ALU_SLL;
                        illegal_o = (funct7 != 7'b0000000); // also rejects shamt[5]
                    end
                    3'b101: begin
                        imm_o = imm_shamt;
                        if (funct7 == 7'b0000000)
                            alu_op_o = ALU_SRL;
                        else if (funct7 == 7'b0100000)
                            alu_op_o = ALU_SRA;
                        else
                            illegal_o = 1'b1;
                    end
                    default: illegal_o = 1'b1;
                endcase
            end
            OPC_OP: begin
                if (funct7 == 7'b0000000) begin
                    alu_op_o = base_op(funct3);
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    alu_op_o = ALU_SUB;
                end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
                    alu_op_o = ALU_SRA;
                end else begin
                    illegal_o = 1'b1;
                end
            end
            OPC_OP_32: begin
                word_op_o = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: alu_op_o = ALU_ADD;
                    {7'b0100000, 3'b000}: alu_op_o = ALU_SUB;
                    {7'b0000000, 3'b001}: alu_op_o = ALU_SLL;
                    {7'b0000000, 3'b101}: alu_op_o = ALU_SRL;
                    {7'b0100000, 3'b101}: alu_op_o = ALU_SRA;
                    default:              illegal_o = 1'b1;
                endcase
            end
            OPC_LUI: begin
                use_imm_o = 1'b1;
                imm_o     = imm_u_type;
                alu_op_o  = ALU_PASS_B;
            end
            OPC_AUIPC: begin
                use_imm_o = 1'b1;
                use_pc_o  = 1'b1; // pc + upper immediate
                imm_o     = imm_u_type;
            end
            default: illegal_o = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [rv_pkg::REG_AW-1:0] rs1_raddr_i,
    input  logic [rv_pkg::REG_AW-1:0] rs2_raddr_i,
    output logic [rv_pkg::XLEN-1:0]   rs1_rdata_o,
    output logic [rv_pkg::XLEN-1:0]   rs2_rdata_o,
    input  logic [rv_pkg::REG_AW-1:0] reg_waddr_i,
    input  logic [rv_pkg::XLEN-1:0]   reg_wdata_i,
    input  logic                      reg_wen_i
);
    import rv_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    // read port 1
    always_comb begin
        if (!rst)
            rs1_rdata_o = '0;
        else if (rs1_raddr_i == '0)
            rs1_rdata_o = '0; // x0 reads zero
        else if (reg_wen_i && reg_waddr_i == rs1_raddr_i)
            rs1_rdata_o = reg_wdata_i; // bypass from writeback
        else
            rs1_rdata_o = regs[rs1_raddr_i];
    end

    // read port 2
    always_comb begin
        if (!rst)
            rs2_rdata_o = '0;
        else if (rs2_raddr_i == '0)
            rs2_rdata_o = '0;
        else if (reg_wen_i && reg_waddr_i == rs2_raddr_i)
            rs2_rdata_o = reg_wdata_i;
        else
            rs2_rdata_o = regs[rs2_raddr_i];
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_wen_i && reg_waddr_i != '0) begin
            regs[reg_waddr_i] <= reg_wdata_i; // x0 writes dropped
        end
    end

endmodule

`default_nettype wire

// ==== design/rv_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_datapath (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      inst_valid_i,
    input  logic [rv_pkg::INST_W-1:0] inst_i,
    input  logic [rv_pkg::XLEN-1:0]   inst_addr_i,
    output logic                      wb_valid_o,
    output logic [rv_pkg::REG_AW-1:0] wb_addr_o,
    output logic [rv_pkg::XLEN-1:0]   wb_data_o,
    output logic                      illegal_o
);
    import rv_pkg::*;

    logic [REG_AW-1:0] rs1_addr;
    logic [REG_AW-1:0] rs2_addr;
    logic [REG_AW-1:0] rd_addr;
    alu_op_e           alu_op;
    logic [XLEN-1:0]   imm;
    logic              use_imm;
    logic              use_pc;
    logic              word_op;
    logic              illegal;
    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;

    inst_decode u_decode (
        .inst_i     (inst_i),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rd_addr_o  (rd_addr),
        .alu_op_o   (alu_op),
        .imm_o      (imm),
        .use_imm_o  (use_imm),
        .use_pc_o   (use_pc),
        .word_op_o  (word_op),
        .illegal_o  (illegal)
    );

    // write port fed back from the writeback register
    reg_file u_regs (
        .clk         (clk),
        .rst         (rst),
        .rs1_raddr_i (rs1_addr),
        .rs2_raddr_i (rs2_addr),
        .rs1_rdata_o (rs1_data),
        .rs2_rdata_o (rs2_data),
        .reg_waddr_i (wb_addr_o),
        .reg_wdata_i (wb_data_o),
        .reg_wen_i   (wb_valid_o)
    );

    alu_exec u_alu (
        .clk          (clk),
        .rst          (rst),
        .inst_valid_i (inst_valid_i),
        .inst_addr_i  (inst_addr_i),
        .alu_op_i     (alu_op),
        .imm_i        (imm),
        .use_imm_i    (use_imm),
        .use_pc_i     (use_pc),
        .word_op_i    (word_op),
        .illegal_i    (illegal),
        .rd_addr_i    (rd_addr),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .wb_valid_o   (wb_valid_o),
        .wb_addr_o    (wb_addr_o),
        .wb_data_o    (wb_data_o),
        .illegal_o    (illegal_o)
    );

endmodule

`default_nettype wire

// ==== design/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    // data and field widths
    localparam int XLEN     = 64;
    localparam int INST_W   = 32;
    localparam int REG_AW   = 5;
    localparam int NUM_REGS = 32;

    // major opcodes, bits [6:0] of the instruction word
    typedef enum logic [6:0] {
        OPC_OP        = 7'b0110011,
        OPC_OP_IMM    = 7'b0010011,
        OPC_OP_32     = 7'b0111011,
        OPC_OP_IMM_32 = 7'b0011011,
        OPC_LUI       = 7'b0110111,
        OPC_AUIPC     = 7'b0010111
    } opcode_e;

    // alu operations
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10 // operand b straight through, for lui
    } alu_op_e;

endpackage

`default_nettype wire

// ==== rv_datapath.f ====
+incdir+tests
design/rv_pkg.sv
design/inst_decode.sv
design/reg_file.sv
design/alu_exec.sv
design/rv_datapath.sv
tests/tb_rv_datapath.sv

// ==== tests/rv_model.svh ====
`ifndef RV_MODEL_SVH
`define RV_MODEL_SVH

// register state as the testbench expects it
logic [XLEN-1:0] arch_regs [32];

function automatic void clear_model();
    for (int i = 0; i < 32; i++) begin
        arch_regs[i] = '0;
    end
endfunction

function automatic logic [XLEN-1:0] read_reg(input logic [4:0] r);
    return (r == 5'd0) ? '0 : arch_regs[r];
endfunction

function automatic void write_reg(input logic [4:0] r, input logic [XLEN-1:0] v);
    if (r != 5'd0)
        arch_regs[r] = v; // x0 stays zero
endfunction

// word forms work on 32 bits, then sign-extend
function automatic logic [XLEN-1:0] predict_alu(input alu_op_e op, input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b, input logic word);
    logic [31:0]     w;
    logic [XLEN-1:0] r;
    if (word) begin
        case (op)
            ALU_SUB: w = a[31:0] - b[31:0];
            ALU_SLL: w = a[31:0] << b[4:0];
            ALU_SRL: w = a[31:0] >> b[4:0];
            ALU_SRA: w = $unsigned($signed(a[31:0]) >>> b[4:0]);
            default: w = a[31:0] + b[31:0];
        endcase
        return {{32{w[31]}}, w};
    end
    case (op)
        ALU_ADD:    r = a + b;
        ALU_SUB:    r = a - b;
        ALU_SLL:    r = a << b[5:0];
        ALU_SLT:    r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
        ALU_SLTU:   r = (a < b) ? 64'd1 : 64'd0;
        ALU_XOR:    r = a ^ b;
        ALU_SRL:    r = a >> b[5:0];
        ALU_SRA:    r = $unsigned($signed(a) >>> b[5:0]);
        ALU_OR:     r = a | b;
        ALU_AND:    r = a & b;
        ALU_PASS_B: r = b;
        default:    r = '0;
    endcase
    return r;
endfunction

`endif

// ==== tests/tb_rv_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv_datapath;
    import rv_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int DRIVE_DLY  = 2;
    localparam int RST_CYCLES = 5;
    localparam int TABLE_LEN  = 36;
    localparam int NUM_RANDOM = 200;
    localparam int WATCHDOG_CYCLES = TABLE_LEN + NUM_RANDOM + 50;
    localparam logic [31:0] SEED = 32'h5c1a;

    typedef struct packed {
        logic [31:0]     inst;
        logic [XLEN-1:0] addr;
        logic [4:0]      rd;
        logic [XLEN-1:0] data;
        logic            ill;
    } entry_t;

    logic              clk = 1'b0;
    logic              rst;
    logic              inst_valid_i;
    logic [31:0]       inst_i;
    logic [XLEN-1:0]   inst_addr_i;
    logic              wb_valid_o;
    logic [REG_AW-1:0] wb_addr_o;
    logic [XLEN-1:0]   wb_data_o;
    logic              illegal_o;

    entry_t tbl [TABLE_LEN];
    string  tbl_name [TABLE_LEN];
    int     n_entries  = 0;
    int     test_errs  = 0;
    int     pass_count = 0;
    int     fail_count = 0;

    `include "rv_model.svh"

    rv_datapath UUT (
        .clk          (clk),
        .rst          (rst),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .inst_addr_i  (inst_addr_i),
        .wb_valid_o   (wb_valid_o),
        .wb_addr_o    (wb_addr_o),
        .wb_data_o    (wb_data_o),
        .illegal_o    (illegal_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] r_type(input opcode_e opc, input logic [6:0] f7,
                                           input logic [4:0] rs2, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] i_type(input opcode_e opc, input logic [11:0] imm,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] u_type(input opcode_e opc, input logic [19:0] imm,
                                           input logic [4:0] rd);
        return {imm, rd, opc};
    endfunction

    task automatic add_entry(input string name, input logic [31:0] inst, input logic [4:0] rd,
                             input logic [XLEN-1:0] data, input logic ill = 1'b0,
                             input logic [XLEN-1:0] addr = '0);
        if (n_entries < TABLE_LEN) begin
            tbl[n_entries]      = '{inst, addr, rd, data, ill};
            tbl_name[n_entries] = name;
        end
        n_entries++;
    endtask

    // expected values worked out by hand, x regs start at zero
    task automatic fill_table();
        add_entry("add after reset", r_type(OPC_OP, 7'h00, 5'd6, 5'd5, 3'b000, 5'd1), 5'd1, 64'd0);
        add_entry("addi", i_type(OPC_OP_IMM, 12'd100, 5'd0, 3'b000, 5'd1), 5'd1, 64'd100);
        add_entry("addi neg", i_type(OPC_OP_IMM, 12'hFFB, 5'd0, 3'b000, 5'd2), 5'd2,
                  64'hFFFF_FFFF_FFFF_FFFB);
        add_entry("slti", i_type(OPC_OP_IMM, 12'hFFC, 5'd2, 3'b010, 5'd3), 5'd3, 64'd1);
        add_entry("sltiu", i_type(OPC_OP_IMM, 12'd5, 5'd2, 3'b011, 5'd4), 5'd4, 64'd0);
        add_entry("xori", i_type(OPC_OP_IMM, 12'hFFF, 5'd1, 3'b100, 5'd5), 5'd5,
                  64'hFFFF_FFFF_FFFF_FF9B);
        add_entry("ori", i_type(OPC_OP_IMM, 12'h0F0, 5'd1, 3'b110, 5'd6), 5'd6, 64'hF4);
        add_entry("andi", i_type(OPC_OP_IMM, 12'h7F0, 5'd2, 3'b111, 5'd7), 5'd7, 64'h7F0);
        add_entry("slli", i_type(OPC_OP_IMM, 12'd40, 5'd1, 3'b001, 5'd8), 5'd8,
                  64'h0000_6400_0000_0000);
        add_entry("srli", i_type(OPC_OP_IMM, 12'd60, 5'd2, 3'b101, 5'd9), 5'd9, 64'hF);
        add_entry("srai", i_type(OPC_OP_IMM, 12'h401, 5'd2, 3'b101, 5'd10), 5'd10,
                  64'hFFFF_FFFF_FFFF_FFFD);
        add_entry("lui", u_type(OPC_LUI, 20'h80000, 5'd11), 5'd11, 64'hFFFF_FFFF_8000_0000);
        add_entry("auipc", u_type(OPC_AUIPC, 20'hFFFFF, 5'd12), 5'd12, 64'h7FFF_F040, 1'b0,
                  64'h8000_0040);
        // chain on x13, each step needs the bypass
        add_entry("chain addi", i_type(OPC_OP_IMM, 12'd1, 5'd0, 3'b000, 5'd13), 5'd13, 64'd1);
        add_entry("chain slli", i_type(OPC_OP_IMM, 12'd4, 5'd13, 3'b001, 5'd13), 5'd13, 64'd16);
        add_entry("chain addi neg", i_type(OPC_OP_IMM, 12'hFFD, 5'd13, 3'b000, 5'd13), 5'd13,
                  64'd13);
        add_entry("chain add", r_type(OPC_OP, 7'h00, 5'd13, 5'd13, 3'b000, 5'd14), 5'd14, 64'd26);
        add_entry("addiw", i_type(OPC_OP_IMM_32, 12'hFFF, 5'd11, 3'b000, 5'd15), 5'd15,
                  64'h0000_0000_7FFF_FFFF);
        add_entry("addw", r_type(OPC_OP_32, 7'h00, 5'd1, 5'd15, 3'b000, 5'd16), 5'd16,
                  64'hFFFF_FFFF_8000_0063);
        add_entry("add", r_type(OPC_OP, 7'h00, 5'd1, 5'd15, 3'b000, 5'd17), 5'd17,
                  64'h0000_0000_8000_0063);
        add_entry("sub", r_type(OPC_OP, 7'h20, 5'd2, 5'd1, 3'b000, 5'd18), 5'd18, 64'd105);
        add_entry("subw", r_type(OPC_OP_32, 7'h20, 5'd15, 5'd0, 3'b000, 5'd19), 5'd19,
                  64'hFFFF_FFFF_8000_0001);
        add_entry("slt", r_type(OPC_OP, 7'h00, 5'd1, 5'd2, 3'b010, 5'd20), 5'd20, 64'd1);
        add_entry("sltu", r_type(OPC_OP, 7'h00, 5'd1, 5'd2, 3'b011, 5'd21), 5'd21, 64'd0);
        add_entry("sll masked", r_type(OPC_OP, 7'h00, 5'd18, 5'd1, 3'b001, 5'd28), 5'd28,
                  64'h0000_C800_0000_0000);
        add_entry("srl", r_type(OPC_OP, 7'h00, 5'd9, 5'd2, 3'b101, 5'd23), 5'd23,
                  64'h0001_FFFF_FFFF_FFFF);
        add_entry("sra", r_type(OPC_OP, 7'h20, 5'd9, 5'd2, 3'b101, 5'd24), 5'd24,
                  64'hFFFF_FFFF_FFFF_FFFF);
        add_entry("sllw", r_type(OPC_OP_32, 7'h00, 5'd9, 5'd15, 3'b001, 5'd25), 5'd25,
                  64'hFFFF_FFFF_FFFF_8000);
        add_entry("srlw masked", r_type(OPC_OP_32, 7'h00, 5'd18, 5'd16, 3'b101, 5'd26), 5'd26,
                  64'h0000_0000_0040_0000);
        add_entry("sraw masked", r_type(OPC_OP_32, 7'h20, 5'd18, 5'd16, 3'b101, 5'd27), 5'd27,
                  64'hFFFF_FFFF_FFC0_0000);
        add_entry("addi to x0", i_type(OPC_OP_IMM, 12'd7, 5'd1, 3'b000, 5'd0), 5'd0, 64'd107);
        add_entry("add to x0", r_type(OPC_OP, 7'h00, 5'd1, 5'd1, 3'b000, 5'd0), 5'd0, 64'd200);
        add_entry("read x0", r_type(OPC_OP, 7'h00, 5'd1, 5'd0, 3'b000, 5'd31), 5'd31, 64'd100);
        add_entry("load opcode", i_type(opcode_e'(7'b0000011), 12'd0, 5'd1, 3'b011, 5'd5), 5'd0,
                  64'd0, 1'b1);
        add_entry("bad funct7", r_type(OPC_OP, 7'h01, 5'd1, 5'd1, 3'b000, 5'd5), 5'd0, 64'd0, 1'b1);
        add_entry("x5 unchanged", r_type(OPC_OP, 7'h00, 5'd0, 5'd5, 3'b000, 5'd30), 5'd30,
                  64'hFFFF_FFFF_FFFF_FF9B);
    endtask

    task automatic funct_for_op(input alu_op_e op, output logic [2:0] f3, output logic [6:0] f7);
        f7 = (op == ALU_SUB || op == ALU_SRA) ? 7'h20 : 7'h00;
        case (op)
            ALU_SLL:  f3 = 3'b001;
            ALU_SLT:  f3 = 3'b010;
            ALU_SLTU: f3 = 3'b011;
            ALU_XOR:  f3 = 3'b100;
            ALU_SRL:  f3 = 3'b101;
            ALU_SRA:  f3 = 3'b101;
            ALU_OR:   f3 = 3'b110;
            ALU_AND:  f3 = 3'b111;
            default:  f3 = 3'b000; // add and sub
        endcase
    endtask

    function automatic alu_op_e pick_word_op(input int unsigned sel, input logic with_sub);
        case (sel % 5)
            0:       return with_sub ? ALU_SUB : ALU_ADD;
            1:       return ALU_SLL;
            2:       return ALU_SRL;
            3:       return ALU_SRA;
            default: return ALU_ADD;
        endcase
    endfunction

    // one random legal instruction, prediction goes into the model right away
    task automatic random_inst(output logic [31:0] inst, output logic [XLEN-1:0] pc,
                               output logic [4:0] rd, output logic [XLEN-1:0] exp);
        alu_op_e         op;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [11:0]     imm12;
        logic [19:0]     imm20;
        logic [2:0]      f3;
        logic [6:0]      f7;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic            shift;
        int unsigned     kind;
        rs1   = 5'($urandom);
        rs2   = 5'($urandom);
        rd    = 5'($urandom);
        imm12 = 12'($urandom);
        imm20 = 20'($urandom);
        pc    = {$urandom, $urandom} & ~64'h3;
        kind  = $urandom % 6;
        a     = read_reg(rs1);
        b     = read_reg(rs2);
        case (kind)
            0:       op = alu_op_e'(4'($urandom % 10));
            1:       op = alu_op_e'(4'($urandom % 10));
            2:       op = pick_word_op($urandom, 1'b1);
            3:       op = pick_word_op($urandom, 1'b0);
            4:       op = ALU_PASS_B;
            default: op = ALU_ADD;
        endcase
        if (kind == 1 && op == ALU_SUB)
            op = ALU_ADD; // no subi
        funct_for_op(op, f3, f7);
        shift = (op == ALU_SLL || op == ALU_SRL || op == ALU_SRA);
        case (kind)
            0: inst = r_type(OPC_OP, f7, rs2, rs1, f3, rd);
            1: begin
                if (shift)
                    imm12 = {f7[6:1], imm12[5:0]};
                b    = {{(XLEN-12){imm12[11]}}, imm12};
                inst = i_type(OPC_OP_IMM, imm12, rs1, f3, rd);
            end
            2: inst = r_type(OPC_OP_32, f7, rs2, rs1, f3, rd);
            3: begin
                if (shift)
                    imm12 = {f7, imm12[4:0]};
                b    = {{(XLEN-12){imm12[11]}}, imm12};
                inst = i_type(OPC_OP_IMM_32, imm12, rs1, f3, rd);
            end
            default: begin
                b    = {{(XLEN-32){imm20[19]}}, imm20, 12'b0};
                a    = pc; // only auipc uses it
                inst = u_type((kind == 4) ? OPC_LUI : OPC_AUIPC, imm20, rd);
            end
        endcase
        exp = predict_alu(op, a, b, kind == 2 || kind == 3);
        write_reg(rd, exp);
    endtask

    task automatic check_idle();
        assert (wb_valid_o === 1'b0) else begin
            $display("ERROR %0t: wb_valid_o is %b, expected 0", $time, wb_valid_o);
            test_errs++;
        end
        assert (illegal_o === 1'b0) else begin
            $display("ERROR %0t: illegal_o is %b, expected 0", $time, illegal_o);
            test_errs++;
        end
    endtask

    task automatic check_result(input logic exp_ill, input logic [4:0] exp_rd,
                                input logic [XLEN-1:0] exp_data);
        assert (wb_valid_o === !exp_ill) else begin
            $display("ERROR %0t: wb_valid_o is %b, expected %b", $time, wb_valid_o, !exp_ill);
            test_errs++;
        end
        assert (illegal_o === exp_ill) else begin
            $display("ERROR %0t: illegal_o is %b, expected %b", $time, illegal_o, exp_ill);
            test_errs++;
        end
        if (!exp_ill) begin
            assert (wb_addr_o === exp_rd) else begin
                $display("ERROR %0t: wb_addr_o is %0d, expected %0d", $time, wb_addr_o, exp_rd);
                test_errs++;
            end
            assert (wb_data_o === exp_data) else begin
                $display("ERROR %0t: wb_data_o is %h, expected %h", $time, wb_data_o, exp_data);
                test_errs++;
            end
        end
    endtask

    task automatic report_test(input string name);
        if (test_errs == 0) begin
            pass_count++;
            $display("test %s: pass", name);
        end else begin
            fail_count++;
            $display("test %s: fail with %0d mismatches", name, test_errs);
        end
        test_errs = 0;
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: run did not end within %0d cycles", WATCHDOG_CYCLES);
        $display("Something failed");
        $finish;
    end

    initial begin
        logic [31:0]     r_inst;
        logic [XLEN-1:0] r_pc;
        logic [4:0]      r_rd;
        logic [XLEN-1:0] r_exp;
        rst          = 1'b0;
        inst_valid_i = 1'b1; // all-zero word, would be illegal outside reset
        inst_i       = '0;
        inst_addr_i  = '0;
        void'($urandom(SEED));
        clear_model();
        fill_table();
        if (n_entries != TABLE_LEN) begin
            $display("stimulus table holds %0d entries instead of %0d", n_entries, TABLE_LEN);
            fail_count++;
        end
        repeat (RST_CYCLES) begin
            @(posedge clk);
            #DRIVE_DLY;
            check_idle();
        end
        rst          = 1'b1;
        inst_valid_i = 1'b0;
        @(posedge clk);
        #DRIVE_DLY;
        check_idle();
        report_test("reset");
        for (int i = 0; i < TABLE_LEN && i < n_entries; i++) begin
            inst_valid_i = 1'b1;
            inst_i       = tbl[i].inst;
            inst_addr_i  = tbl[i].addr;
            if (!tbl[i].ill)
                write_reg(tbl[i].rd, tbl[i].data);
            @(posedge clk);
            #DRIVE_DLY;
            check_result(tbl[i].ill, tbl[i].rd, tbl[i].data);
            report_test(tbl_name[i]);
        end
        for (int i = 0; i < NUM_RANDOM; i++) begin
            random_inst(r_inst, r_pc, r_rd, r_exp);
            inst_i      = r_inst;
            inst_addr_i = r_pc;
            @(posedge clk);
            #DRIVE_DLY;
            check_result(1'b0, r_rd, r_exp);
        end
        inst_valid_i = 1'b0;
        report_test("random stream");
        $display("summary: %0d tests passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
